// ==== mipsSettings.svh ====
`ifndef MIPS_SETTINGS_SVH
`define MIPS_SETTINGS_SVH

`define XLEN       32
`define REG_ADDR_W 5
`define RESET_PC   32'hBFC00000

`define OP_RTYPE   6'b000000
`define OP_ADDIU   6'b001001
`define OP_ORI     6'b001101
`define OP_LUI     6'b001111
`define OP_LW      6'b100011
`define OP_SW      6'b101011
`define OP_BEQ     6'b000100
`define OP_BNE     6'b000101

`define FN_ADDU    6'b100001
`define FN_SUBU    6'b100011
`define FN_AND     6'b100100
`define FN_OR      6'b100101
`define FN_SLT     6'b101010

`define FWD_RF     2'd0
`define FWD_MEM    2'd1
`define FWD_WB     2'd2

`endif

// ==== mipsPkg.sv ====
`include "mipsSettings.svh"

package mipsPkg;

    typedef logic [`XLEN-1:0]       wordT;
    typedef logic [`REG_ADDR_W-1:0] regAddrT;

    typedef enum logic [3:0] {
        aluAdd,    // zero value, so a bubble decodes as add
        aluSub,
        aluAnd,
        aluOr,
        aluSlt,
        aluLui
    } aluOpT;

    typedef struct packed {
        logic  regWrite;
        logic  memRead;
        logic  memWrite;
        logic  useImm;   // srcB from immediate
        logic  branch;
        logic  branchNe; // bne rather than beq
        logic  destRt;   // write rt instead of rd
        aluOpT aluOp;
    } ctrlT;

    typedef struct packed {
        wordT pc;
        wordT instr;
    } fdPayloadT;

    typedef struct packed {
        wordT    pc;
        ctrlT    ctrl;
        regAddrT rs;
        regAddrT rt;
        regAddrT rd;
        wordT    rsVal;
        wordT    rtVal;
        wordT    imm;
    } dePayloadT;

    typedef struct packed {
        wordT    pc;
        ctrlT    ctrl;
        wordT    aluOut;
        wordT    storeVal; // forwarded rt for sw
        regAddrT writeReg;
    } emPayloadT;

    typedef struct packed {
        wordT    pc;
        logic    regWrite;
        wordT    result;
        regAddrT writeReg;
    } mwPayloadT;

endpackage

// ==== pipeStage.sv ====
`timescale 1ns/100ps

module pipeStage import mipsPkg::*; #(
    parameter type payloadT = wordT
) (
    input  logic    clk,
    input  logic    rstN_i,
    input  logic    stall_i,
    input  logic    flush_i,
    input  payloadT d_i,
    output payloadT q_o
);

    // a bubble is the all-zero payload: no regWrite, no memory access
    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            q_o <= '0;
        end else if (flush_i) begin
            q_o <= '0;    // flush beats stall
        end else if (!stall_i) begin
            q_o <= d_i;
        end
    end

endmodule

// ==== mainDecoder.sv ====
`timescale 1ns/100ps
`include "mipsSettings.svh"

module mainDecoder import mipsPkg::*; (
    input  wordT instr_i,
    output ctrlT ctrl_o,
    output wordT imm_o
);

    logic [5:0] opcode;
    logic [5:0] funct;
    logic       zeroExt;

    assign opcode = instr_i[31:26];
    assign funct  = instr_i[5:0];

    always_comb begin
        ctrl_o  = '0;     // unknown opcode stays a no-op
        zeroExt = 1'b0;
        case (opcode)
            `OP_RTYPE: begin
                ctrl_o.regWrite = 1'b1;
                case (funct)
                    `FN_ADDU: ctrl_o.aluOp = aluAdd;
                    `FN_SUBU: ctrl_o.aluOp = aluSub;
                    `FN_AND:  ctrl_o.aluOp = aluAnd;
                    `FN_OR:   ctrl_o.aluOp = aluOr;
                    `FN_SLT:  ctrl_o.aluOp = aluSlt;
                    default:  ctrl_o.regWrite = 1'b0; // unsupported funct
                endcase
            end
            `OP_ADDIU: begin
                ctrl_o.regWrite = 1'b1;
                ctrl_o.useImm   = 1'b1;
                ctrl_o.destRt   = 1'b1;
            end
            `OP_ORI: begin
                ctrl_o.regWrite = 1'b1;
                ctrl_o.useImm   = 1'b1;
                ctrl_o.destRt   = 1'b1;
                ctrl_o.aluOp    = aluOr;
                zeroExt         = 1'b1;
            end
            `OP_LUI: begin
                ctrl_o.regWrite = 1'b1;
                ctrl_o.useImm   = 1'b1;
                ctrl_o.destRt   = 1'b1;
                ctrl_o.aluOp    = aluLui;
                zeroExt         = 1'b1;
            end
            `OP_LW: begin
                ctrl_o.regWrite = 1'b1;
                ctrl_o.memRead  = 1'b1;
                ctrl_o.useImm   = 1'b1;
                ctrl_o.destRt   = 1'b1;
            end
            `OP_SW: begin
                ctrl_o.memWrite = 1'b1;
                ctrl_o.useImm   = 1'b1;
            end
            `OP_BEQ: ctrl_o.branch = 1'b1;
            `OP_BNE: begin
                ctrl_o.branch   = 1'b1;
                ctrl_o.branchNe = 1'b1;
            end
            default: ctrl_o = '0;
        endcase
    end

    assign imm_o = zeroExt ? {{(`XLEN-16){1'b0}}, instr_i[15:0]}
                           : {{(`XLEN-16){instr_i[15]}}, instr_i[15:0]};

endmodule

// ==== regFile.sv ====
`timescale 1ns/100ps

module regFile import mipsPkg::*; (
    input  logic    clk,
    input  logic    rstN_i,
    input  logic    we_i,
    input  regAddrT waddr_i,
    input  wordT    wdata_i,
    input  regAddrT raddr1_i,
    input  regAddrT raddr2_i,
    output wordT    rdata1_o,
    output wordT    rdata2_o
);

    wordT regs [1:31];    // $0 is not stored

    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // writeback and decode share a cycle, so pass the new value through
    assign rdata1_o = (raddr1_i == '0)                  ? '0      :
                      (we_i && waddr_i == raddr1_i)     ? wdata_i : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0)                  ? '0      :
                      (we_i && waddr_i == raddr2_i)     ? wdata_i : regs[raddr2_i];

endmodule

// ==== aluUnit.sv ====
`timescale 1ns/100ps

module aluUnit import mipsPkg::*; (
    input  aluOpT op_i,
    input  wordT  srcA_i,
    input  wordT  srcB_i,
    input  logic  branchNe_i,
    output wordT  result_o,
    output logic  branchTaken_o
);

    logic isEqual;

    always_comb begin
        case (op_i)
            aluAdd:  result_o = srcA_i + srcB_i;
            aluSub:  result_o = srcA_i - srcB_i;
            aluAnd:  result_o = srcA_i & srcB_i;
            aluOr:   result_o = srcA_i | srcB_i;
            aluSlt:  result_o = wordT'($signed(srcA_i) < $signed(srcB_i)); // signed compare
            aluLui:  result_o = {srcB_i[15:0], 16'b0};
            default: result_o = '0;
        endcase
    end

    // raw compare, top level qualifies with ctrl.branch
    assign isEqual       = (srcA_i == srcB_i);
    assign branchTaken_o = branchNe_i ? ~isEqual : isEqual;

endmodule

// ==== hazardUnit.sv ====
`timescale 1ns/100ps
`include "mipsSettings.svh"

module hazardUnit import mipsPkg::*; (
    input  regAddrT    rsD_i,
    input  regAddrT    rtD_i,
    input  regAddrT    rsE_i,
    input  regAddrT    rtE_i,
    input  regAddrT    writeRegE_i,
    input  regAddrT    writeRegM_i,
    input  regAddrT    writeRegW_i,
    input  logic       memReadE_i,
    input  logic       regWriteM_i,
    input  logic       regWriteW_i,
    input  logic       branchTakenE_i,
    output logic       stallF_o,
    output logic       stallD_o,
    output logic       flushD_o,
    output logic       flushE_o,
    output logic [1:0] fwdA_o,
    output logic [1:0] fwdB_o
);

    logic loadUse;

    // newest producer wins, $0 never forwards
    function automatic logic [1:0] fwdSel(input regAddrT src);
        if (regWriteM_i && writeRegM_i != '0 && writeRegM_i == src) begin
            return `FWD_MEM;
        end else if (regWriteW_i && writeRegW_i != '0 && writeRegW_i == src) begin
            return `FWD_WB;
        end
        return `FWD_RF;
    endfunction

    always_comb begin
        fwdA_o = fwdSel(rsE_i);
        fwdB_o = fwdSel(rtE_i);
    end

    assign loadUse = memReadE_i && writeRegE_i != '0 &&
                     (writeRegE_i == rsD_i || writeRegE_i == rtD_i);

    assign stallF_o = loadUse;
    assign stallD_o = loadUse;
    assign flushD_o = branchTakenE_i;            // squash the two younger ones
    assign flushE_o = branchTakenE_i | loadUse;  // bubble into execute

endmodule

// ==== datapath.sv ====
`timescale 1ns/100ps
`include "mipsSettings.svh"

module datapath import mipsPkg::*; (
    input  logic       clk,
    input  logic       rstN_i,
    // instruction port
    output wordT       instAddr_o,
    output logic       instEn_o,
    input  wordT       instr_i,
    // data port
    output logic       memEn_o,
    output wordT       memAddr_o,
    output logic [3:0] memWen_o,
    output wordT       memWdata_o,
    input  wordT       memRdata_i,
    // writeback debug
    output wordT       debugPc_o,
    output logic [3:0] debugRfWen_o,
    output regAddrT    debugRfWnum_o,
    output wordT       debugRfWdata_o
);

    wordT       pcF;
    wordT       pcNext;
    wordT       pcPlus4F;
    logic       stallF;
    logic       stallD;
    logic       flushD;
    logic       flushE;
    logic [1:0] fwdA;
    logic [1:0] fwdB;

    fdPayloadT  fdIn;
    fdPayloadT  fdOut;
    dePayloadT  deIn;
    dePayloadT  deOut;
    emPayloadT  emIn;
    emPayloadT  emOut;
    mwPayloadT  mwIn;
    mwPayloadT  mwOut;

    regAddrT    rsD;
    regAddrT    rtD;
    regAddrT    rdD;
    ctrlT       ctrlD;
    wordT       immD;
    wordT       rsValD;
    wordT       rtValD;

    wordT       srcAE;
    wordT       srcBE;
    wordT       rtFwdE;
    wordT       aluOutE;
    logic       cmpTakenE;
    logic       branchTakenE;
    wordT       branchTargetE;
    regAddrT    writeRegE;

    wordT       resultM;

    function automatic wordT fwdMux(input logic [1:0] sel, input wordT rfVal,
                                    input wordT memVal, input wordT wbVal);
        case (sel)
            `FWD_MEM: return memVal;
            `FWD_WB:  return wbVal;
            default:  return rfVal;
        endcase
    endfunction

    // fetch
    assign pcPlus4F = pcF + wordT'(4);

    always_comb begin
        if (branchTakenE) begin
            pcNext = branchTargetE;   // resolved in execute
        end else if (stallF) begin
            pcNext = pcF;
        end else begin
            pcNext = pcPlus4F;
        end
    end

    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            pcF <= `RESET_PC;
        end else begin
            pcF <= pcNext;
        end
    end

    assign instAddr_o = pcF;
    assign instEn_o   = ~stallF & ~branchTakenE; // fetched word is dropped anyway

    assign fdIn = '{pc: pcF, instr: instr_i};

    pipeStage #(.payloadT(fdPayloadT)) fdStage (
        .clk     (clk),
        .rstN_i  (rstN_i),
        .stall_i (stallD),
        .flush_i (flushD),
        .d_i     (fdIn),
        .q_o     (fdOut)
    );

    // decode
    assign rsD = fdOut.instr[25:21];
    assign rtD = fdOut.instr[20:16];
    assign rdD = fdOut.instr[15:11];

    mainDecoder decoder (
        .instr_i (fdOut.instr),
        .ctrl_o  (ctrlD),
        .imm_o   (immD)
    );

    regFile rf (
        .clk      (clk),
        .rstN_i   (rstN_i),
        .we_i     (mwOut.regWrite),
        .waddr_i  (mwOut.writeReg),
        .wdata_i  (mwOut.result),
        .raddr1_i (rsD),
        .raddr2_i (rtD),
        .rdata1_o (rsValD),
        .rdata2_o (rtValD)
    );

    assign deIn = '{
        pc:    fdOut.pc,
        ctrl:  ctrlD,
        rs:    rsD,
        rt:    rtD,
        rd:    rdD,
        rsVal: rsValD,
        rtVal: rtValD,
        imm:   immD
    };

    pipeStage #(.payloadT(dePayloadT)) deStage (
        .clk     (clk),
        .rstN_i  (rstN_i),
        .stall_i (1'b0),
        .flush_i (flushE),
        .d_i     (deIn),
        .q_o     (deOut)
    );

    // execute
    assign srcAE  = fwdMux(fwdA, deOut.rsVal, resultM, mwOut.result);
    assign rtFwdE = fwdMux(fwdB, deOut.rtVal, resultM, mwOut.result);
    assign srcBE  = deOut.ctrl.useImm ? deOut.imm : rtFwdE;

    aluUnit alu (
        .op_i          (deOut.ctrl.aluOp),
        .srcA_i        (srcAE),
        .srcB_i        (srcBE),
        .branchNe_i    (deOut.ctrl.branchNe),
        .result_o      (aluOutE),
        .branchTaken_o (cmpTakenE)
    );

    assign branchTakenE  = deOut.ctrl.branch & cmpTakenE;
    assign branchTargetE = deOut.pc + wordT'(4) + {deOut.imm[`XLEN-3:0], 2'b00};
    assign writeRegE     = deOut.ctrl.destRt ? deOut.rt : deOut.rd;

    assign emIn = '{
        pc:       deOut.pc,
        ctrl:     deOut.ctrl,
        aluOut:   aluOutE,
        storeVal: rtFwdE,
        writeReg: writeRegE
    };

    pipeStage #(.payloadT(emPayloadT)) emStage (
        .clk     (clk),
        .rstN_i  (rstN_i),
        .stall_i (1'b0),
        .flush_i (1'b0),
        .d_i     (emIn),
        .q_o     (emOut)
    );

    // memory, word access only
    assign memEn_o    = emOut.ctrl.memRead | emOut.ctrl.memWrite;
    assign memAddr_o  = emOut.aluOut;
    assign memWen_o   = {4{emOut.ctrl.memWrite}};
    assign memWdata_o = emOut.storeVal;
    assign resultM    = emOut.ctrl.memRead ? memRdata_i : emOut.aluOut;

    assign mwIn = '{
        pc:       emOut.pc,
        regWrite: emOut.ctrl.regWrite,
        result:   resultM,
        writeReg: emOut.writeReg
    };

    pipeStage #(.payloadT(mwPayloadT)) mwStage (
        .clk     (clk),
        .rstN_i  (rstN_i),
        .stall_i (1'b0),
        .flush_i (1'b0),
        .d_i     (mwIn),
        .q_o     (mwOut)
    );

    // writeback trace
    assign debugPc_o      = mwOut.pc;
    assign debugRfWen_o   = {4{mwOut.regWrite}};
    assign debugRfWnum_o  = mwOut.writeReg;
    assign debugRfWdata_o = mwOut.result;

    hazardUnit hazard (
        .rsD_i          (rsD),
        .rtD_i          (rtD),
        .rsE_i          (deOut.rs),
        .rtE_i          (deOut.rt),
        .writeRegE_i    (writeRegE),
        .writeRegM_i    (emOut.writeReg),
        .writeRegW_i    (mwOut.writeReg),
        .memReadE_i     (deOut.ctrl.memRead),
        .regWriteM_i    (emOut.ctrl.regWrite),
        .regWriteW_i    (mwOut.regWrite),
        .branchTakenE_i (branchTakenE),
        .stallF_o       (stallF),
        .stallD_o       (stallD),
        .flushD_o       (flushD),
        .flushE_o       (flushE),
        .fwdA_o         (fwdA),
        .fwdB_o         (fwdB)
    );

endmodule

// ==== datapathTb.sv ====
`timescale 1ns/100ps
`include "mipsSettings.svh"

module datapathTb import mipsPkg::*; ();

    localparam int progLen    = 31;
    localparam int traceLen   = 19;
    localparam int memChecks  = 5;
    localparam int cycleLimit = 3 * progLen + 20;

    logic       clk;
    logic       rstN;
    wordT       instAddr;
    logic       instEn;
    wordT       instr;
    logic       memEn;
    wordT       memAddr;
    logic [3:0] memWen;
    wordT       memWdata;
    wordT       memRdata;
    wordT       debugPc;
    logic [3:0] debugRfWen;
    regAddrT    debugRfWnum;
    wordT       debugRfWdata;

    wordT    imem [64];
    wordT    dmem [64];
    wordT    prog [progLen];
    int      expIdx [traceLen];    // program slot of the writer
    regAddrT expNum [traceLen];
    wordT    expVal [traceLen];
    wordT    memAddrTab [memChecks];
    wordT    memValTab [memChecks];

    int traceIdx        = 0;
    int cycles          = 0;
    int wbMismatches    = 0;
    int busFaults       = 0;
    int valueMismatches = 0;
    int runFaults       = 0;

    datapath uut (
        .clk            (clk),
        .rstN_i         (rstN),
        .instAddr_o     (instAddr),
        .instEn_o       (instEn),
        .instr_i        (instr),
        .memEn_o        (memEn),
        .memAddr_o      (memAddr),
        .memWen_o       (memWen),
        .memWdata_o     (memWdata),
        .memRdata_i     (memRdata),
        .debugPc_o      (debugPc),
        .debugRfWen_o   (debugRfWen),
        .debugRfWnum_o  (debugRfWnum),
        .debugRfWdata_o (debugRfWdata)
    );

    function automatic wordT rTypeWord(input logic [5:0] fn, input regAddrT rd,
                                       input regAddrT rs, input regAddrT rt);
        return {`OP_RTYPE, rs, rt, rd, 5'd0, fn};
    endfunction

    // operand order follows the assembly form: op rt, rs, imm
    function automatic wordT iTypeWord(input logic [5:0] op, input regAddrT rt,
                                       input regAddrT rs, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic wordT fillWord(input wordT addr);
        return addr ^ 32'hDA7A0000;
    endfunction

    task automatic expectWrite(input int row, input int idx, input regAddrT num,
                               input wordT val);
        expIdx[row] = idx;
        expNum[row] = num;
        expVal[row] = val;
    endtask

    task automatic expectWord(input int row, input wordT addr, input wordT val);
        memAddrTab[row] = addr;
        memValTab[row]  = val;
    endtask

    task automatic loadTables();
        prog[0]  = iTypeWord(`OP_ADDIU, 5'd1, 5'd0, 16'd5);
        prog[1]  = iTypeWord(`OP_ADDIU, 5'd2, 5'd0, 16'hFFFD);     // -3
        prog[2]  = rTypeWord(`FN_ADDU, 5'd3, 5'd1, 5'd2);          // distance 2 and 1
        prog[3]  = rTypeWord(`FN_SUBU, 5'd4, 5'd2, 5'd1);
        prog[4]  = rTypeWord(`FN_SLT, 5'd5, 5'd2, 5'd1);           // -3 < 5
        prog[5]  = rTypeWord(`FN_SLT, 5'd6, 5'd1, 5'd2);
        prog[6]  = iTypeWord(`OP_ORI, 5'd7, 5'd0, 16'h8001);       // zero extended
        prog[7]  = iTypeWord(`OP_LUI, 5'd8, 5'd0, 16'h1234);
        prog[8]  = rTypeWord(`FN_OR, 5'd9, 5'd8, 5'd7);
        prog[9]  = rTypeWord(`FN_AND, 5'd10, 5'd9, 5'd4);
        prog[10] = iTypeWord(`OP_ADDIU, 5'd0, 5'd0, 16'd7);        // write to $0
        prog[11] = rTypeWord(`FN_ADDU, 5'd11, 5'd0, 5'd1);         // $0 must read 0
        prog[12] = iTypeWord(`OP_SW, 5'd9, 5'd0, 16'd8);
        prog[13] = iTypeWord(`OP_SW, 5'd4, 5'd0, 16'd12);
        prog[14] = iTypeWord(`OP_LW, 5'd12, 5'd0, 16'd8);
        prog[15] = rTypeWord(`FN_ADDU, 5'd13, 5'd12, 5'd1);        // load-use on rs
        prog[16] = iTypeWord(`OP_LW, 5'd14, 5'd0, 16'd16);         // untouched word
        prog[17] = iTypeWord(`OP_ADDIU, 5'd15, 5'd14, 16'd1);
        prog[18] = iTypeWord(`OP_BEQ, 5'd11, 5'd1, 16'd2);         // taken, to slot 21
        prog[19] = iTypeWord(`OP_ADDIU, 5'd16, 5'd0, 16'h0066);
        prog[20] = iTypeWord(`OP_ADDIU, 5'd17, 5'd0, 16'h0077);
        prog[21] = iTypeWord(`OP_BNE, 5'd2, 5'd1, 16'd2);          // taken, to slot 24
        prog[22] = iTypeWord(`OP_ADDIU, 5'd16, 5'd0, 16'h0055);
        prog[23] = iTypeWord(`OP_ADDIU, 5'd17, 5'd0, 16'h0055);
        prog[24] = iTypeWord(`OP_BEQ, 5'd2, 5'd1, 16'd2);          // not taken
        prog[25] = iTypeWord(`OP_ADDIU, 5'd18, 5'd0, 16'h0012);
        prog[26] = iTypeWord(`OP_BNE, 5'd11, 5'd1, 16'd1);         // not taken
        prog[27] = iTypeWord(`OP_ADDIU, 5'd19, 5'd18, 16'hFFFF);
        prog[28] = iTypeWord(`OP_SW, 5'd19, 5'd0, 16'd24);         // store data forwarded
        prog[29] = rTypeWord(`FN_ADDU, 5'd20, 5'd19, 5'd15);
        prog[30] = iTypeWord(`OP_SW, 5'd20, 5'd0, 16'd28);

        expectWrite(0, 0, 5'd1, 32'h00000005);
        expectWrite(1, 1, 5'd2, 32'hFFFFFFFD);
        expectWrite(2, 2, 5'd3, 32'h00000002);
        expectWrite(3, 3, 5'd4, 32'hFFFFFFF8);
        expectWrite(4, 4, 5'd5, 32'h00000001);
        expectWrite(5, 5, 5'd6, 32'h00000000);
        expectWrite(6, 6, 5'd7, 32'h00008001);
        expectWrite(7, 7, 5'd8, 32'h12340000);
        expectWrite(8, 8, 5'd9, 32'h12348001);
        expectWrite(9, 9, 5'd10, 32'h12348000);
        expectWrite(10, 10, 5'd0, 32'h00000007);   // strobe still fires for $0
        expectWrite(11, 11, 5'd11, 32'h00000005);
        expectWrite(12, 14, 5'd12, 32'h12348001);
        expectWrite(13, 15, 5'd13, 32'h12348006);
        expectWrite(14, 16, 5'd14, 32'hDA7A0010);
        expectWrite(15, 17, 5'd15, 32'hDA7A0011);
        expectWrite(16, 25, 5'd18, 32'h00000012);
        expectWrite(17, 27, 5'd19, 32'h00000011);
        expectWrite(18, 29, 5'd20, 32'hDA7A0022);

        expectWord(0, 32'd8, 32'h12348001);
        expectWord(1, 32'd12, 32'hFFFFFFF8);
        expectWord(2, 32'd16, 32'hDA7A0010);
        expectWord(3, 32'd24, 32'h00000011);
        expectWord(4, 32'd28, 32'hDA7A0022);
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
    end

    // combinational reads, a disabled port returns zero, program sits at the reset PC
    assign instr    = instEn ? imem[instAddr[7:2]] : 32'h0;
    assign memRdata = memEn ? dmem[memAddr[7:2]] : 32'h0;

    always @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < 64; i++) begin
                dmem[i] <= fillWord(wordT'(i * 4));   // address-derived start value
            end
        end else if (memEn && memWen != 4'h0) begin
            dmem[memAddr[7:2]] <= memWdata;
        end
    end

    always @(posedge clk) begin
        assert (!rstN || memWen == 4'h0 || memWen == 4'hF) else begin
            busFaults++;
            $display("partial byte enable %b on the word-only data bus at %0t", memWen, $time);
        end
        assert (!rstN || !memEn || memAddr[31:8] == 24'h0) else begin
            busFaults++;
            $display("data access outside the test memory at %0t, address %h", $time, memAddr);
        end
        if (traceIdx == 0) begin
            assert (memWen == 4'h0) else begin
                busFaults++;
                $display("memory write seen before the first writeback at %0t", $time);
            end
        end
        if (debugRfWen != 4'h0) begin
            assert (traceIdx < traceLen) else begin
                busFaults++;
                $display("unexpected extra register write at %0t: r%0d = %h",
                         $time, debugRfWnum, debugRfWdata);
            end
            if (traceIdx < traceLen) begin
                assert (debugRfWen == 4'hF) else begin
                    wbMismatches++;
                    $display("mismatch at %0t: debugRfWen_o got %b, expected 1111",
                             $time, debugRfWen);
                end
                assert (debugPc == `RESET_PC + wordT'(expIdx[traceIdx] * 4)) else begin
                    wbMismatches++;
                    $display("mismatch at %0t: debugPc_o got %h, expected %h", $time,
                             debugPc, `RESET_PC + wordT'(expIdx[traceIdx] * 4));
                end
                assert (debugRfWnum == expNum[traceIdx]) else begin
                    wbMismatches++;
                    $display("mismatch at %0t: debugRfWnum_o got %0d, expected %0d",
                             $time, debugRfWnum, expNum[traceIdx]);
                end
                assert (debugRfWdata == expVal[traceIdx]) else begin
                    wbMismatches++;
                    $display("mismatch at %0t: debugRfWdata_o got %h, expected %h",
                             $time, debugRfWdata, expVal[traceIdx]);
                end
                traceIdx <= traceIdx + 1;
            end
        end
    end

    initial begin
        rstN = 1'b0;
        loadTables();
        for (int i = 0; i < 64; i++) begin
            imem[i] = (i < progLen) ? prog[i] : 32'h0;   // nop past the program
        end
        repeat (3) begin
            @(negedge clk);
            assert (instAddr == `RESET_PC) else begin
                valueMismatches++;
                $display("mismatch at %0t: instAddr_o got %h, expected %h",
                         $time, instAddr, `RESET_PC);
            end
            assert (debugRfWen == 4'h0 && memWen == 4'h0 && memEn == 1'b0) else begin
                runFaults++;
                $display("write strobe or memory enable active during reset at %0t", $time);
            end
        end
        @(posedge clk);
        rstN <= 1'b1;

        while (traceIdx < traceLen && cycles < cycleLimit) begin
            @(posedge clk);
        end
        if (traceIdx < traceLen) begin
            runFaults++;
            $display("timeout after %0d cycles, only %0d of %0d expected writebacks seen",
                     cycles, traceIdx, traceLen);
        end else begin
            repeat (6) @(posedge clk);   // last store lands, stray writes show up
        end
        @(negedge clk);

        for (int i = 0; i < memChecks; i++) begin
            assert (dmem[memAddrTab[i][7:2]] == memValTab[i]) else begin
                valueMismatches++;
                $display("mismatch at %0t: dmem[%h] got %h, expected %h", $time,
                         memAddrTab[i], dmem[memAddrTab[i][7:2]], memValTab[i]);
            end
        end

        $display("errors: writeback %0d, value %0d, bus %0d, run %0d",
                 wbMismatches, valueMismatches, busFaults, runFaults);
        if (wbMismatches + valueMismatches + busFaults + runFaults == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== datapath.f ====
+incdir+.
mipsPkg.sv
pipeStage.sv
mainDecoder.sv
regFile.sv
aluUnit.sv
hazardUnit.sv
datapath.sv
datapathTb.sv

// ==== Makefile ====
TOOL      = verilator
FLAGS     = --binary --timing --assert
LINTFLAGS = --lint-only --timing -Wall
TOP       = datapathTb
FLIST     = datapath.f
LOG       = sim.log

SOURCES = $(shell grep -v '^+' $(FLIST)) mipsSettings.svh

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): $(FLIST) $(SOURCES)
	$(TOOL) $(FLAGS) -f $(FLIST) --top-module $(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q '>>> FAIL' $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q '>>> PASS' $(LOG) || { echo "simulation ended without a verdict"; exit 1; }

lint:
	$(TOOL) $(LINTFLAGS) -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)
